//--- scaler_pkg.sv
package scaler_pkg;

    // bus widths
    typedef logic [7:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;

    // scaler values and indices
    typedef logic [15:0] count_t;
    typedef logic [4:0]  chan_idx_t;
    typedef logic [2:0]  gate_sel_t;
    typedef logic [1:0]  ctrl_idx_t;

    // channel counts
    localparam int NUM_L1_CH   = 32;
    localparam int NUM_L2_CH   = 24;
    localparam int NUM_GP_GATE = 6;

    // a counter holds here once it gets to the top
    localparam count_t CNT_MAX = '1;

    // gate select codes, 1..6 pick gp_gate_i[sel-1]
    localparam gate_sel_t GATE_OPEN   = 3'd0;
    localparam gate_sel_t GATE_CLOSED = 3'd7;

    // control register indices
    localparam ctrl_idx_t CTRL_IDX_GATE = 2'd0;
    localparam ctrl_idx_t CTRL_IDX_MASK = 2'd1;
    localparam ctrl_idx_t CTRL_IDX_PPS  = 2'd2;

    // address map: bank one from 0x00, control from 0x80, bank two from 0xA0
    localparam wb_adr_t CTRL_BASE = 8'h80;
    localparam wb_adr_t L2_BASE   = 8'hA0;
    // word index of the first bank two channel
    localparam int L2_WORD_OFS = L2_BASE >> 2;

endpackage

//--- scaler_trigger_sync.sv
`timescale 1ns/1ps

module scaler_trigger_sync (
    input  logic                               wb_clk_i,
    input  logic                               rst_n_i,
    input  logic [scaler_pkg::NUM_L1_CH-1:0]   trig_i,
    input  logic [scaler_pkg::NUM_L2_CH-1:0]   leveltwo_i,
    input  logic                               pps_i,
    input  logic [scaler_pkg::NUM_GP_GATE-1:0] gp_gate_i,
    input  scaler_pkg::gate_sel_t              gate_sel_i,
    input  scaler_pkg::wb_dat_t                gate_en_i,
    output logic [scaler_pkg::NUM_L1_CH-1:0]   l1_hit_o,
    output logic [scaler_pkg::NUM_L2_CH-1:0]   l2_hit_o,
    output logic                               pps_tick_o
);

    // all async inputs travel together through the same flop chain
    localparam int SYNC_W = scaler_pkg::NUM_L1_CH + scaler_pkg::NUM_L2_CH + 1
                            + scaler_pkg::NUM_GP_GATE;

    logic [SYNC_W-1:0] sync_q1;
    logic [SYNC_W-1:0] sync_q2;
    logic [SYNC_W-1:0] prev_q;
    logic [SYNC_W-1:0] rise;
    logic [scaler_pkg::NUM_GP_GATE-1:0] gp_gate_s;
    logic gate;

    // gp gates sit in the low bits, then pps, then level two, then level one
    assign gp_gate_s = sync_q2[scaler_pkg::NUM_GP_GATE-1:0];
    assign rise      = sync_q2 & ~prev_q;

    // gate source selection on the synchronized level
    always_comb begin
        case (gate_sel_i)
            scaler_pkg::GATE_OPEN:   gate = 1'b1;
            scaler_pkg::GATE_CLOSED: gate = 1'b0;
            default:                 gate = gp_gate_s[gate_sel_i - 3'd1];
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            sync_q1    <= '0;
            sync_q2    <= '0;
            prev_q     <= '0;
            l1_hit_o   <= '0;
            l2_hit_o   <= '0;
            pps_tick_o <= 1'b0;
        end else begin
            sync_q1 <= {trig_i, leveltwo_i, pps_i, gp_gate_i};
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
            l1_hit_o <= rise[SYNC_W-1 -: scaler_pkg::NUM_L1_CH]
                        & gate_en_i[scaler_pkg::NUM_L1_CH-1:0]
                        & {scaler_pkg::NUM_L1_CH{gate}};
            // bank two uses the low mask bits
            l2_hit_o <= rise[scaler_pkg::NUM_GP_GATE+1 +: scaler_pkg::NUM_L2_CH]
                        & gate_en_i[scaler_pkg::NUM_L2_CH-1:0]
                        & {scaler_pkg::NUM_L2_CH{gate}};
            // pps is never gated
            pps_tick_o <= rise[scaler_pkg::NUM_GP_GATE];
        end
    end

endmodule

//--- scaler_counter_bank.sv
`timescale 1ns/1ps

module scaler_counter_bank #(
    parameter int NUM_CH = scaler_pkg::NUM_L1_CH
) (
    input  logic                  wb_clk_i,
    input  logic                  rst_n_i,
    input  logic [NUM_CH-1:0]     hit_i,
    input  logic                  pps_tick_i,
    input  scaler_pkg::chan_idx_t rd_idx_i,
    output scaler_pkg::count_t    rd_cnt_o
);

    // running counts for the current interval
    scaler_pkg::count_t cnt_q [NUM_CH];
    // counts of the last finished interval, seen by the bus
    scaler_pkg::count_t hold_q [NUM_CH];

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_CH; i++) begin
                cnt_q[i]  <= '0;
                hold_q[i] <= '0;
            end
        end else if (pps_tick_i) begin
            for (int i = 0; i < NUM_CH; i++) begin
                hold_q[i] <= cnt_q[i];
                // a hit on the tick is the first event of the new interval
                cnt_q[i]  <= hit_i[i] ? scaler_pkg::count_t'(1) : '0;
            end
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                // saturate at the top
                if (hit_i[i] && (cnt_q[i] != scaler_pkg::CNT_MAX)) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    // indexed read, channels past the bank read zero
    always_comb begin
        if (int'(rd_idx_i) < NUM_CH) begin
            rd_cnt_o = hold_q[rd_idx_i];
        end else begin
            rd_cnt_o = '0;
        end
    end

endmodule

//--- scaler_ctrl_regs.sv
`timescale 1ns/1ps

module scaler_ctrl_regs (
    input  logic                  wb_clk_i,
    input  logic                  rst_n_i,
    input  logic                  we_i,
    input  scaler_pkg::ctrl_idx_t idx_i,
    input  scaler_pkg::wb_dat_t   wdat_i,
    input  logic                  pps_tick_i,
    output scaler_pkg::wb_dat_t   rdat_o,
    output scaler_pkg::gate_sel_t gate_sel_o,
    output scaler_pkg::wb_dat_t   gate_en_o
);

    scaler_pkg::gate_sel_t gate_sel_q;
    scaler_pkg::wb_dat_t   gate_en_q;
    scaler_pkg::wb_dat_t   pps_cnt_q;

    // writable registers, pps count and index 3 take no writes
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            gate_sel_q <= scaler_pkg::GATE_OPEN;
            gate_en_q  <= '1;
        end else if (we_i) begin
            if (idx_i == scaler_pkg::CTRL_IDX_GATE) begin
                gate_sel_q <= wdat_i[2:0];
            end
            if (idx_i == scaler_pkg::CTRL_IDX_MASK) begin
                gate_en_q <= wdat_i;
            end
        end
    end

    // free running tick counter, wraps at 32 bits
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            pps_cnt_q <= '0;
        end else if (pps_tick_i) begin
            pps_cnt_q <= pps_cnt_q + 1'b1;
        end
    end

    always_comb begin
        case (idx_i)
            scaler_pkg::CTRL_IDX_GATE: rdat_o = scaler_pkg::wb_dat_t'(gate_sel_q);
            scaler_pkg::CTRL_IDX_MASK: rdat_o = gate_en_q;
            scaler_pkg::CTRL_IDX_PPS:  rdat_o = pps_cnt_q;
            default:                   rdat_o = '0;
        endcase
    end

    assign gate_sel_o = gate_sel_q;
    assign gate_en_o  = gate_en_q;

endmodule

//--- scaler_wb_readout.sv
`timescale 1ns/1ps

module scaler_wb_readout (
    input  logic                  wb_clk_i,
    input  logic                  rst_n_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  scaler_pkg::wb_adr_t   wb_adr_i,
    input  scaler_pkg::wb_dat_t   wb_dat_i,
    input  logic [3:0]            wb_sel_i,
    output scaler_pkg::wb_dat_t   wb_dat_o,
    output logic                  wb_ack_o,
    output scaler_pkg::chan_idx_t l1_idx_o,
    output scaler_pkg::chan_idx_t l2_idx_o,
    output scaler_pkg::ctrl_idx_t ctrl_idx_o,
    output logic                  ctrl_we_o,
    output scaler_pkg::wb_dat_t   ctrl_wdat_o,
    input  scaler_pkg::count_t    l1_cnt_i,
    input  scaler_pkg::count_t    l2_cnt_i,
    input  scaler_pkg::wb_dat_t   ctrl_rdat_i
);

    logic                ack_q;
    scaler_pkg::wb_dat_t dat_q;
    scaler_pkg::wb_dat_t rd_mux;
    logic [5:0]          word;
    logic                in_l1;
    logic                in_ctrl;
    logic                start;

    // region decode on the byte address
    assign in_l1   = wb_adr_i < scaler_pkg::CTRL_BASE;
    assign in_ctrl = !in_l1 && (wb_adr_i < scaler_pkg::L2_BASE);
    assign word    = wb_adr_i[7:2];

    assign l1_idx_o   = wb_adr_i[6:2];
    assign ctrl_idx_o = wb_adr_i[3:2];
    // bank two starts at word 40
    assign l2_idx_o   = scaler_pkg::chan_idx_t'(word - 6'(scaler_pkg::L2_WORD_OFS));

    // first cycle of an access, byte lanes are not used
    assign start = wb_cyc_i && wb_stb_i && !ack_q;

    // writes only land in the control region
    assign ctrl_we_o   = start && wb_we_i && in_ctrl;
    assign ctrl_wdat_o = wb_dat_i;

    always_comb begin
        if (in_l1) begin
            rd_mux = scaler_pkg::wb_dat_t'(l1_cnt_i);
        end else if (in_ctrl) begin
            rd_mux = ctrl_rdat_i;
        end else begin
            rd_mux = scaler_pkg::wb_dat_t'(l2_cnt_i);
        end
    end

    // one ack per access, dropped the cycle after
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= start;
        end
    end

    // read data captured together with the ack
    always_ff @(posedge wb_clk_i) begin
        if (start) begin
            dat_q <= rd_mux;
        end
    end

    assign wb_ack_o = ack_q && wb_cyc_i;
    assign wb_dat_o = dat_q;

endmodule

//--- scaler_top.sv
`timescale 1ns/1ps

module scaler_top (
    input  logic                               wb_clk_i,
    input  logic                               rst_n_i,
    input  logic                               wb_cyc_i,
    input  logic                               wb_stb_i,
    input  logic                               wb_we_i,
    input  scaler_pkg::wb_adr_t                wb_adr_i,
    input  scaler_pkg::wb_dat_t                wb_dat_i,
    input  logic [3:0]                         wb_sel_i,
    output scaler_pkg::wb_dat_t                wb_dat_o,
    output logic                               wb_ack_o,
    input  logic                               pps_i,
    input  logic [scaler_pkg::NUM_GP_GATE-1:0] gp_gate_i,
    input  logic [scaler_pkg::NUM_L1_CH-1:0]   trig_i,
    input  logic [scaler_pkg::NUM_L2_CH-1:0]   leveltwo_i
);

    logic [scaler_pkg::NUM_L1_CH-1:0] l1_hit;
    logic [scaler_pkg::NUM_L2_CH-1:0] l2_hit;
    logic                             pps_tick;
    scaler_pkg::chan_idx_t            l1_idx;
    scaler_pkg::chan_idx_t            l2_idx;
    scaler_pkg::ctrl_idx_t            ctrl_idx;
    logic                             ctrl_we;
    scaler_pkg::wb_dat_t              ctrl_wdat;
    scaler_pkg::wb_dat_t              ctrl_rdat;
    scaler_pkg::count_t               l1_cnt;
    scaler_pkg::count_t               l2_cnt;
    scaler_pkg::gate_sel_t            gate_sel;
    scaler_pkg::wb_dat_t              gate_en;

    scaler_trigger_sync u_trigger_sync (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .trig_i     (trig_i),
        .leveltwo_i (leveltwo_i),
        .pps_i      (pps_i),
        .gp_gate_i  (gp_gate_i),
        .gate_sel_i (gate_sel),
        .gate_en_i  (gate_en),
        .l1_hit_o   (l1_hit),
        .l2_hit_o   (l2_hit),
        .pps_tick_o (pps_tick)
    );

    scaler_counter_bank #(.NUM_CH(scaler_pkg::NUM_L1_CH)) u_l1_bank (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .hit_i      (l1_hit),
        .pps_tick_i (pps_tick),
        .rd_idx_i   (l1_idx),
        .rd_cnt_o   (l1_cnt)
    );

    scaler_counter_bank #(.NUM_CH(scaler_pkg::NUM_L2_CH)) u_l2_bank (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .hit_i      (l2_hit),
        .pps_tick_i (pps_tick),
        .rd_idx_i   (l2_idx),
        .rd_cnt_o   (l2_cnt)
    );

    scaler_ctrl_regs u_ctrl_regs (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .we_i       (ctrl_we),
        .idx_i      (ctrl_idx),
        .wdat_i     (ctrl_wdat),
        .pps_tick_i (pps_tick),
        .rdat_o     (ctrl_rdat),
        .gate_sel_o (gate_sel),
        .gate_en_o  (gate_en)
    );

    scaler_wb_readout u_wb_readout (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .l1_idx_o    (l1_idx),
        .l2_idx_o    (l2_idx),
        .ctrl_idx_o  (ctrl_idx),
        .ctrl_we_o   (ctrl_we),
        .ctrl_wdat_o (ctrl_wdat),
        .l1_cnt_i    (l1_cnt),
        .l2_cnt_i    (l2_cnt),
        .ctrl_rdat_i (ctrl_rdat)
    );

endmodule

//--- tb_scaler_tasks.svh
// compare a value with its expected value
task automatic check(input string name, input logic [31:0] got,
                     input logic [31:0] expected);
    if (got !== expected) begin
        $display("Mismatch at %0t: %s got 0x%08h expected 0x%08h",
                 $time, name, got, expected);
        mismatch_cnt++;
    end
endtask

// byte addresses from the address map
function automatic scaler_pkg::wb_adr_t l1_addr(input int ch);
    return scaler_pkg::wb_adr_t'(ch * 4);
endfunction

function automatic scaler_pkg::wb_adr_t l2_addr(input int ch);
    return scaler_pkg::L2_BASE + scaler_pkg::wb_adr_t'(ch * 4);
endfunction

function automatic scaler_pkg::wb_adr_t ctrl_addr(input int idx);
    return scaler_pkg::CTRL_BASE + scaler_pkg::wb_adr_t'(idx * 4);
endfunction

// one classic cycle, cyc and stb held until ack
task automatic bus_cycle(input logic we, input scaler_pkg::wb_adr_t adr,
                         input scaler_pkg::wb_dat_t wdat,
                         output scaler_pkg::wb_dat_t rdat);
    int wait_cnt;
    wait_cnt = 0;
    rdat = '0;
    @(posedge wb_clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    // ack and data are looked at on the falling edge
    @(negedge wb_clk);
    while (!wb_ack && wait_cnt < ACK_TIMEOUT) begin
        @(negedge wb_clk);
        wait_cnt++;
    end
    if (wb_ack) begin
        rdat = wb_dat_r;
        // ack comes in the second cycle of the access
        check("ack latency", wait_cnt, 1);
    end else begin
        $display("no ack from the DUT within %0d cycles, address 0x%02h", ACK_TIMEOUT, adr);
        fail_cnt++;
    end
    @(posedge wb_clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
endtask

task automatic wb_write(input scaler_pkg::wb_adr_t adr, input scaler_pkg::wb_dat_t dat);
    scaler_pkg::wb_dat_t rdat_ignored;
    bus_cycle(1'b1, adr, dat, rdat_ignored);
endtask

task automatic wb_read(input scaler_pkg::wb_adr_t adr, output scaler_pkg::wb_dat_t dat);
    bus_cycle(1'b0, adr, '0, dat);
endtask

// two cycles high, two cycles low on one trigger line
task automatic pulse_chan(input logic bank_two, input int ch);
    @(posedge wb_clk);
    if (bank_two) begin
        lvl2 <= 24'h1 << ch;
    end else begin
        trig <= 32'h1 << ch;
    end
    repeat (2) @(posedge wb_clk);
    trig <= '0;
    lvl2 <= '0;
    @(posedge wb_clk);
endtask

// pps edge, then time for the tick to reach the holding registers
task automatic pps_pulse();
    @(posedge wb_clk);
    pps <= 1'b1;
    pps_sent++;
    repeat (2) @(posedge wb_clk);
    pps <= 1'b0;
    repeat (6) @(posedge wb_clk);
endtask

task automatic clear_expected();
    foreach (exp_l1[i]) exp_l1[i] = 0;
    foreach (exp_l2[i]) exp_l2[i] = 0;
endtask

// read every channel of both banks
task automatic check_counts();
    scaler_pkg::wb_dat_t rdat;
    for (int ch = 0; ch < 32; ch++) begin
        wb_read(l1_addr(ch), rdat);
        check($sformatf("l1 count %0d", ch), rdat, exp_l1[ch]);
    end
    for (int ch = 0; ch < 24; ch++) begin
        wb_read(l2_addr(ch), rdat);
        check($sformatf("l2 count %0d", ch), rdat, exp_l2[ch]);
    end
endtask

//--- tb_scaler.sv
`timescale 1ns/1ps

module tb_scaler;

    localparam int SAT_PULSES  = 70000;
    // each pulse_chan call takes 4 cycles, everything else fits in 20000
    localparam int WATCHDOG_CYCLES = SAT_PULSES * 4 + 20000;
    localparam int ACK_TIMEOUT = 16;

    logic                wb_clk;
    logic                rst_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    scaler_pkg::wb_adr_t wb_adr;
    scaler_pkg::wb_dat_t wb_dat_w;
    logic [3:0]          wb_sel;
    scaler_pkg::wb_dat_t wb_dat_r;
    logic                wb_ack;
    logic                pps;
    logic [5:0]          gp_gate;
    logic [31:0]         trig;
    logic [23:0]         lvl2;

    int          mismatch_cnt = 0;
    int          fail_cnt = 0;
    // pps edges sent since reset
    int unsigned pps_sent = 0;
    int unsigned exp_l1 [32];
    int unsigned exp_l2 [24];

    scaler_top u_scaler_top (
        .wb_clk_i   (wb_clk),
        .rst_n_i    (rst_n),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_we_i    (wb_we),
        .wb_adr_i   (wb_adr),
        .wb_dat_i   (wb_dat_w),
        .wb_sel_i   (wb_sel),
        .wb_dat_o   (wb_dat_r),
        .wb_ack_o   (wb_ack),
        .pps_i      (pps),
        .gp_gate_i  (gp_gate),
        .trig_i     (trig),
        .leveltwo_i (lvl2)
    );

    initial begin
        wb_clk = 1'b0;
        forever #20 wb_clk = ~wb_clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge wb_clk);
        $display("run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    `include "tb_scaler_tasks.svh"

    task automatic reset_values();
        scaler_pkg::wb_dat_t rdat;
        wb_read(ctrl_addr(0), rdat);
        check("gate select", rdat, 0);
        wb_read(ctrl_addr(1), rdat);
        check("enable mask", rdat, 32'hffff_ffff);
        wb_read(ctrl_addr(2), rdat);
        check("pps count", rdat, 0);
        clear_expected();
        check_counts();
    endtask

    task automatic register_access();
        scaler_pkg::wb_dat_t mask;
        scaler_pkg::wb_dat_t sel;
        scaler_pkg::wb_dat_t rdat;
        int ch;
        mask = $urandom();
        sel  = $urandom();
        // a bank one channel whose low index bits point at the mask register
        ch   = 4 * ($urandom % 8) + 1;
        wb_write(ctrl_addr(1), mask);
        wb_write(ctrl_addr(0), sel);
        // a bank one write and a pps count write change nothing
        wb_write(l1_addr(ch), ~mask);
        wb_write(ctrl_addr(2), $urandom() | 32'h1);
        wb_read(ctrl_addr(1), rdat);
        check("enable mask", rdat, mask);
        wb_read(ctrl_addr(0), rdat);
        check("gate select", rdat, sel & 32'h7);
        wb_read(ctrl_addr(2), rdat);
        check("pps count", rdat, 0);
        wb_read(ctrl_addr(3), rdat);
        check("ctrl index 3", rdat, 0);
        wb_read(l1_addr(ch), rdat);
        check($sformatf("l1 count %0d", ch), rdat, 0);
        wb_write(ctrl_addr(0), 0);
        wb_write(ctrl_addr(1), 32'hffff_ffff);
    endtask

    task automatic interval_counting();
        int ch;
        int n;
        scaler_pkg::wb_dat_t rdat;
        clear_expected();
        wb_read(ctrl_addr(2), rdat);
        check("pps count", rdat, pps_sent);
        for (int i = 0; i < 4; i++) begin
            ch = $urandom % 32;
            n  = 1 + $urandom % 20;
            exp_l1[ch] += n;
            repeat (n) pulse_chan(1'b0, ch);
            ch = $urandom % 24;
            n  = 1 + $urandom % 20;
            exp_l2[ch] += n;
            repeat (n) pulse_chan(1'b1, ch);
        end
        pps_pulse();
        check_counts();
        wb_read(ctrl_addr(2), rdat);
        check("pps count", rdat, pps_sent);
        // an interval with no pulses
        clear_expected();
        pps_pulse();
        check_counts();
    endtask

    task automatic enable_mask();
        scaler_pkg::wb_dat_t mask;
        int n;
        mask = $urandom();
        wb_write(ctrl_addr(1), mask);
        clear_expected();
        for (int ch = 0; ch < 32; ch++) begin
            if ($urandom % 2 == 1) begin
                n = 1 + $urandom % 20;
                repeat (n) pulse_chan(1'b0, ch);
                exp_l1[ch] = (((mask >> ch) & 32'h1) != 0) ? n : 0;
            end
        end
        // bank two follows the low 24 mask bits
        for (int ch = 0; ch < 24; ch++) begin
            if ($urandom % 2 == 1) begin
                n = 1 + $urandom % 20;
                repeat (n) pulse_chan(1'b1, ch);
                exp_l2[ch] = (((mask >> ch) & 32'h1) != 0) ? n : 0;
            end
        end
        pps_pulse();
        check_counts();
        wb_write(ctrl_addr(1), 32'hffff_ffff);
    endtask

    task automatic gate_selection();
        int ch1;
        int ch2;
        int na;
        int nb;
        int expected;
        logic [5:0] sel_bit;
        scaler_pkg::wb_dat_t rdat;
        for (int sel = 0; sel < 8; sel++) begin
            wb_write(ctrl_addr(0), sel);
            sel_bit = (sel >= 1 && sel <= 6) ? 6'(1 << (sel - 1)) : 6'h00;
            ch1 = $urandom % 32;
            ch2 = $urandom % 24;
            na  = 1 + $urandom % 20;
            nb  = 1 + $urandom % 20;
            // selected input low, all the others high
            @(posedge wb_clk);
            gp_gate <= ~sel_bit;
            repeat (na) pulse_chan(1'b0, ch1);
            repeat (na) pulse_chan(1'b1, ch2);
            // only the selected input high
            @(posedge wb_clk);
            gp_gate <= sel_bit;
            repeat (nb) pulse_chan(1'b0, ch1);
            repeat (nb) pulse_chan(1'b1, ch2);
            pps_pulse();
            if (sel == 0) begin
                expected = na + nb;
            end else if (sel == 7) begin
                expected = 0;
            end else begin
                expected = nb;
            end
            wb_read(l1_addr(ch1), rdat);
            check($sformatf("l1 count %0d, gate select %0d", ch1, sel), rdat, expected);
            wb_read(l2_addr(ch2), rdat);
            check($sformatf("l2 count %0d, gate select %0d", ch2, sel), rdat, expected);
        end
        wb_write(ctrl_addr(0), 0);
        @(posedge wb_clk);
        gp_gate <= '0;
    endtask

    task automatic saturation();
        int ch;
        scaler_pkg::wb_dat_t rdat;
        ch = $urandom % 32;
        repeat (SAT_PULSES) pulse_chan(1'b0, ch);
        pps_pulse();
        wb_read(l1_addr(ch), rdat);
        // a full 16-bit count, zero-extended on the bus
        check($sformatf("l1 count %0d", ch), rdat, 32'h0000_ffff);
    endtask

    initial begin
        void'($urandom(32'h1aef));
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = 4'hf;
        pps      = 1'b0;
        gp_gate  = '0;
        trig     = '0;
        lvl2     = '0;
        repeat (5) @(posedge wb_clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge wb_clk);
        reset_values();
        register_access();
        interval_counting();
        enable_mask();
        gate_selection();
        saturation();
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+.
scaler_pkg.sv
scaler_trigger_sync.sv
scaler_counter_bank.sv
scaler_ctrl_regs.sv
scaler_wb_readout.sv
scaler_top.sv
tb_scaler.sv

//--- Makefile
TOP = tb_scaler

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f src.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
